/* src/fpss_pkg.sv */
package fpss_pkg;

    localparam int unsigned NameWidth = 5;
    localparam int unsigned NumBanks  = 4;
    localparam int unsigned FLEN      = 32;

    // Instruction opcodes
    typedef enum logic [3:0] {
        OP_MV_W_X,
        OP_MV_X_W,
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_MIN,
        OP_MAX,
        OP_FLW,
        OP_FSW
    } opcode_e;

    // Execution unit of an instruction
    typedef enum logic {
        UNIT_SGNJ,
        UNIT_LSU
    } unit_e;

endpackage

/* src/fpss_wb_if.sv */
interface fpss_wb_if #(
    parameter int unsigned PhysAddrWidth = 6,
    parameter int unsigned RspIdWidth    = 4
);

    logic                      valid;
    logic                      ready;
    logic [PhysAddrWidth-1:0]  rd_addr;
    logic [fpss_pkg::FLEN-1:0] data;
    logic                      to_rsp;
    logic [RspIdWidth-1:0]     id;

    modport unit (
        output valid, rd_addr, data, to_rsp, id,
        input  ready
    );

    modport wb (
        input  valid, rd_addr, data, to_rsp, id,
        output ready
    );

endinterface

/* src/fpss_issue_if.sv */
interface fpss_issue_if #(
    parameter int unsigned PhysAddrWidth = 6,
    parameter int unsigned RspIdWidth    = 4
);

    // One handshake pair per unit
    logic                      sgnj_valid;
    logic                      sgnj_ready;
    logic                      lsu_valid;
    logic                      lsu_ready;

    fpss_pkg::opcode_e         op;
    logic [PhysAddrWidth-1:0]  rd_addr;
    logic [fpss_pkg::FLEN-1:0] rs1_data;
    logic [fpss_pkg::FLEN-1:0] rs2_data;
    logic [fpss_pkg::FLEN-1:0] imm;
    logic [RspIdWidth-1:0]     id;

    modport issue (
        output sgnj_valid, lsu_valid, op, rd_addr, rs1_data, rs2_data, imm, id,
        input  sgnj_ready, lsu_ready
    );

    modport sgnj (
        input  sgnj_valid, op, rd_addr, rs1_data, rs2_data, imm, id,
        output sgnj_ready
    );

    modport lsu (
        input  lsu_valid, op, rd_addr, rs2_data, imm,
        output lsu_ready
    );

endinterface

/* src/fpss_issue.sv */
module fpss_issue #(
    parameter int unsigned PhysAddrWidth = 6,
    parameter int unsigned RspIdWidth    = 4
) (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     instr_valid_i,
    output logic                                     instr_ready_o,
    input  fpss_pkg::opcode_e                        instr_op_i,
    input  logic [fpss_pkg::NameWidth-1:0]           instr_rd_i,
    input  logic [fpss_pkg::NameWidth-1:0]           instr_rs1_i,
    input  logic [fpss_pkg::NameWidth-1:0]           instr_rs2_i,
    input  logic [fpss_pkg::FLEN-1:0]                instr_imm_i,
    input  logic [RspIdWidth-1:0]                    instr_id_i,
    input  logic                                     cfg_write_i,
    input  logic [$clog2(fpss_pkg::NumBanks)-1:0]    cfg_bank_i,
    input  logic [31:0]                              cfg_wdata_i,
    output logic [31:0]                              cfg_rdata_o,
    output logic [PhysAddrWidth-1:0]                 rf_raddr1_o,
    output logic [PhysAddrWidth-1:0]                 rf_raddr2_o,
    input  logic [fpss_pkg::FLEN-1:0]                rf_rdata1_i,
    input  logic [fpss_pkg::FLEN-1:0]                rf_rdata2_i,
    input  logic                                     clr_valid_i,
    input  logic [PhysAddrWidth-1:0]                 clr_addr_i,
    fpss_issue_if.issue                              issue
);

    localparam int unsigned LowWidth = fpss_pkg::NameWidth - 2;
    localparam int unsigned OffWidth = PhysAddrWidth - LowWidth;
    localparam int unsigned NumRegs  = 2 ** PhysAddrWidth;

    logic [fpss_pkg::NumBanks-1:0][OffWidth-1:0] offset_q;
    logic [NumRegs-1:0]                          pending_q;
    logic [PhysAddrWidth-1:0]                    rd_addr;
    fpss_pkg::unit_e                             unit;
    logic                                        uses_rs1;
    logic                                        uses_rs2;
    logic                                        writes_rd;
    logic                                        unit_ready;
    logic                                        hazard;
    logic                                        dispatch;

    // --------------------
    // Offset registers
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < fpss_pkg::NumBanks; i++) begin
                offset_q[i] <= OffWidth'(i);
            end
        end else if (cfg_write_i) begin
            offset_q[cfg_bank_i] <= cfg_wdata_i[OffWidth-1:0];
        end
    end

    assign cfg_rdata_o = 32'(offset_q[cfg_bank_i]);

    // Bank bits pick the offset, low bits pass through
    assign rf_raddr1_o = {offset_q[instr_rs1_i[fpss_pkg::NameWidth-1:LowWidth]],
                          instr_rs1_i[LowWidth-1:0]};
    assign rf_raddr2_o = {offset_q[instr_rs2_i[fpss_pkg::NameWidth-1:LowWidth]],
                          instr_rs2_i[LowWidth-1:0]};
    assign rd_addr     = {offset_q[instr_rd_i[fpss_pkg::NameWidth-1:LowWidth]],
                          instr_rd_i[LowWidth-1:0]};

    // --------------------
    // Decode
    // --------------------
    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        unit      = fpss_pkg::UNIT_SGNJ;
        case (instr_op_i)
            fpss_pkg::OP_MV_W_X: writes_rd = 1'b1;
            fpss_pkg::OP_MV_X_W: uses_rs1 = 1'b1;
            fpss_pkg::OP_SGNJ, fpss_pkg::OP_SGNJN, fpss_pkg::OP_SGNJX,
            fpss_pkg::OP_MIN, fpss_pkg::OP_MAX: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
            end
            fpss_pkg::OP_FLW: begin
                unit      = fpss_pkg::UNIT_LSU;
                writes_rd = 1'b1;
            end
            fpss_pkg::OP_FSW: begin
                unit     = fpss_pkg::UNIT_LSU;
                uses_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

    // RAW on sources, WAW on rd
    assign hazard = (uses_rs1 && pending_q[rf_raddr1_o])
                 || (uses_rs2 && pending_q[rf_raddr2_o])
                 || (writes_rd && (pending_q[rd_addr]
                                   || (clr_valid_i && clr_addr_i == rd_addr)));

    assign unit_ready    = (unit == fpss_pkg::UNIT_LSU) ? issue.lsu_ready : issue.sgnj_ready;
    assign instr_ready_o = unit_ready && !hazard;
    assign dispatch      = instr_valid_i && instr_ready_o;

    assign issue.sgnj_valid = instr_valid_i && !hazard && unit == fpss_pkg::UNIT_SGNJ;
    assign issue.lsu_valid  = instr_valid_i && !hazard && unit == fpss_pkg::UNIT_LSU;
    assign issue.op         = instr_op_i;
    assign issue.rd_addr    = rd_addr;
    assign issue.rs1_data   = rf_rdata1_i;
    assign issue.rs2_data   = rf_rdata2_i;
    assign issue.imm        = instr_imm_i;
    assign issue.id         = instr_id_i;

    // --------------------
    // Scoreboard
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
        end else begin
            if (clr_valid_i) begin
                pending_q[clr_addr_i] <= 1'b0;
            end
            if (dispatch && writes_rd) begin
                pending_q[rd_addr] <= 1'b1;
            end
        end
    end

    a_clr_pending: assert property (@(posedge clk_i) disable iff (reset_i)
        clr_valid_i |-> pending_q[clr_addr_i]);

    a_one_unit: assert property (@(posedge clk_i) disable iff (reset_i)
        !(issue.sgnj_valid && issue.lsu_valid));

endmodule

/* src/fpss_regfile.sv */
module fpss_regfile #(
    parameter int unsigned PhysAddrWidth = 6
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [PhysAddrWidth-1:0]  raddr1_i,
    input  logic [PhysAddrWidth-1:0]  raddr2_i,
    output logic [fpss_pkg::FLEN-1:0] rdata1_o,
    output logic [fpss_pkg::FLEN-1:0] rdata2_o,
    input  logic                      we_i,
    input  logic [PhysAddrWidth-1:0]  waddr_i,
    input  logic [fpss_pkg::FLEN-1:0] wdata_i
);

    localparam int unsigned NumRegs = 2 ** PhysAddrWidth;

    logic [fpss_pkg::FLEN-1:0] regs_q [NumRegs];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads
    assign rdata1_o = regs_q[raddr1_i];
    assign rdata2_o = regs_q[raddr2_i];

endmodule

/* src/fpss_sgnj_unit.sv */
module fpss_sgnj_unit #(
    parameter int unsigned PhysAddrWidth = 6,
    parameter int unsigned RspIdWidth    = 4
) (
    input  logic       clk_i,
    input  logic       reset_i,
    fpss_issue_if.sgnj issue,
    fpss_wb_if.unit    wb
);

    logic                      sign_a;
    logic                      sign_b;
    logic [fpss_pkg::FLEN-2:0] mag_a;
    logic [fpss_pkg::FLEN-2:0] mag_b;
    logic                      a_lt_b;
    logic [fpss_pkg::FLEN-1:0] result;
    logic                      to_rsp;
    logic                      accept;

    logic                      valid_q;
    logic [fpss_pkg::FLEN-1:0] data_q;
    logic [PhysAddrWidth-1:0]  rd_q;
    logic [RspIdWidth-1:0]     id_q;
    logic                      to_rsp_q;

    assign {sign_a, mag_a} = issue.rs1_data;
    assign {sign_b, mag_b} = issue.rs2_data;

    // Sign first, then magnitude; -0 sorts below +0
    always_comb begin
        if (sign_a != sign_b) begin
            a_lt_b = sign_a;
        end else if (sign_a) begin
            a_lt_b = mag_a > mag_b;
        end else begin
            a_lt_b = mag_a < mag_b;
        end
    end

    always_comb begin
        result = issue.rs1_data;
        to_rsp = 1'b0;
        case (issue.op)
            fpss_pkg::OP_MV_W_X: result = issue.imm;
            fpss_pkg::OP_MV_X_W: to_rsp = 1'b1;
            fpss_pkg::OP_SGNJ:   result = {sign_b, mag_a};
            fpss_pkg::OP_SGNJN:  result = {~sign_b, mag_a};
            fpss_pkg::OP_SGNJX:  result = {sign_a ^ sign_b, mag_a};
            fpss_pkg::OP_MIN:    result = a_lt_b ? issue.rs1_data : issue.rs2_data;
            fpss_pkg::OP_MAX:    result = a_lt_b ? issue.rs2_data : issue.rs1_data;
            default: ;
        endcase
    end

    // Single output slot
    assign issue.sgnj_ready = !valid_q || wb.ready;
    assign accept           = issue.sgnj_valid && issue.sgnj_ready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (wb.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q   <= result;
            rd_q     <= issue.rd_addr;
            id_q     <= issue.id;
            to_rsp_q <= to_rsp;
        end
    end

    assign wb.valid   = valid_q;
    assign wb.data    = data_q;
    assign wb.rd_addr = rd_q;
    assign wb.id      = id_q;
    assign wb.to_rsp  = to_rsp_q;

endmodule

/* src/fpss_lsu.sv */
module fpss_lsu #(
    parameter int unsigned PhysAddrWidth  = 6,
    parameter int unsigned MemAddrWidth   = 16,
    parameter int unsigned MaxOutstanding = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    fpss_issue_if.lsu                 issue,
    fpss_wb_if.unit                   wb,
    output logic                      mem_req_o,
    output logic                      mem_we_o,
    output logic [MemAddrWidth-1:0]   mem_addr_o,
    output logic [fpss_pkg::FLEN-1:0] mem_wdata_o,
    input  logic                      mem_gnt_i,
    input  logic                      mem_rvalid_i,
    input  logic [fpss_pkg::FLEN-1:0] mem_rdata_i
);

    localparam int unsigned PtrWidth = (MaxOutstanding > 1) ? $clog2(MaxOutstanding) : 1;
    localparam int unsigned CntWidth = $clog2(MaxOutstanding + 1);

    logic [PhysAddrWidth-1:0] tag_q [MaxOutstanding];
    logic [PtrWidth-1:0]      wptr_q;
    logic [PtrWidth-1:0]      rptr_q;
    logic [CntWidth-1:0]      count_q;
    logic                     is_store;
    logic                     full;
    logic                     push;

    function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(MaxOutstanding - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign is_store = issue.op == fpss_pkg::OP_FSW;
    assign full     = count_q == CntWidth'(MaxOutstanding);

    // --------------------
    // Request side
    // --------------------
    assign mem_req_o   = issue.lsu_valid && (is_store || !full);
    assign mem_we_o    = is_store;
    assign mem_addr_o  = issue.imm[MemAddrWidth-1:0];
    assign mem_wdata_o = issue.rs2_data;

    // Stores retire on grant, loads also need a free tag slot
    assign issue.lsu_ready = mem_gnt_i && (is_store || !full);
    assign push            = issue.lsu_valid && issue.lsu_ready && !is_store;

    // --------------------
    // Tag queue
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= next_ptr(wptr_q);
            end
            if (mem_rvalid_i) begin
                rptr_q <= next_ptr(rptr_q);
            end
            count_q <= count_q + CntWidth'(push) - CntWidth'(mem_rvalid_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            tag_q[wptr_q] <= issue.rd_addr;
        end
    end

    // In-order return pairs with the oldest tag
    assign wb.valid   = mem_rvalid_i;
    assign wb.rd_addr = tag_q[rptr_q];
    assign wb.data    = mem_rdata_i;
    assign wb.to_rsp  = 1'b0;
    assign wb.id      = '0;

    a_rvalid_tagged: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_rvalid_i |-> count_q != '0);

    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        count_q <= CntWidth'(MaxOutstanding));

endmodule

/* src/fpss_writeback.sv */
module fpss_writeback #(
    parameter int unsigned PhysAddrWidth = 6,
    parameter int unsigned RspIdWidth    = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    fpss_wb_if.wb                     sgnj,
    fpss_wb_if.wb                     lsu,
    output logic                      rf_we_o,
    output logic [PhysAddrWidth-1:0]  rf_waddr_o,
    output logic [fpss_pkg::FLEN-1:0] rf_wdata_o,
    output logic                      clr_valid_o,
    output logic [PhysAddrWidth-1:0]  clr_addr_o,
    output logic                      rsp_valid_o,
    input  logic                      rsp_ready_i,
    output logic [fpss_pkg::FLEN-1:0] rsp_data_o,
    output logic [RspIdWidth-1:0]     rsp_id_o
);

    logic                      rsp_free;
    logic                      fire;
    logic                      sel_to_rsp;
    logic [fpss_pkg::FLEN-1:0] sel_data;
    logic [PhysAddrWidth-1:0]  sel_rd;
    logic [RspIdWidth-1:0]     sel_id;

    logic                      rsp_valid_q;
    logic [fpss_pkg::FLEN-1:0] rsp_data_q;
    logic [RspIdWidth-1:0]     rsp_id_q;

    assign rsp_free = !rsp_valid_q || rsp_ready_i;

    // LSU wins, it cannot hold its data
    assign lsu.ready  = !lsu.to_rsp || rsp_free;
    assign sgnj.ready = !lsu.valid && (!sgnj.to_rsp || rsp_free);

    assign sel_to_rsp = lsu.valid ? lsu.to_rsp  : sgnj.to_rsp;
    assign sel_data   = lsu.valid ? lsu.data    : sgnj.data;
    assign sel_rd     = lsu.valid ? lsu.rd_addr : sgnj.rd_addr;
    assign sel_id     = lsu.valid ? lsu.id      : sgnj.id;
    assign fire       = lsu.valid ? lsu.ready   : (sgnj.valid && sgnj.ready);

    assign rf_we_o     = fire && !sel_to_rsp;
    assign rf_waddr_o  = sel_rd;
    assign rf_wdata_o  = sel_data;
    assign clr_valid_o = rf_we_o;
    assign clr_addr_o  = sel_rd;

    // --------------------
    // Response register
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else if (fire && sel_to_rsp) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire && sel_to_rsp) begin
            rsp_data_q <= sel_data;
            rsp_id_q   <= sel_id;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;
    assign rsp_id_o    = rsp_id_q;

endmodule

/* src/fpss_top.sv */
module fpss_top #(
    parameter int unsigned PhysAddrWidth  = 6,
    parameter int unsigned MemAddrWidth   = 16,
    parameter int unsigned MaxOutstanding = 4,
    parameter int unsigned RspIdWidth     = 4
) (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    // Instruction port
    input  logic                                  instr_valid_i,
    output logic                                  instr_ready_o,
    input  fpss_pkg::opcode_e                     instr_op_i,
    input  logic [fpss_pkg::NameWidth-1:0]        instr_rd_i,
    input  logic [fpss_pkg::NameWidth-1:0]        instr_rs1_i,
    input  logic [fpss_pkg::NameWidth-1:0]        instr_rs2_i,
    input  logic [fpss_pkg::FLEN-1:0]             instr_imm_i,
    input  logic [RspIdWidth-1:0]                 instr_id_i,
    // Offset configuration
    input  logic                                  cfg_write_i,
    input  logic [$clog2(fpss_pkg::NumBanks)-1:0] cfg_bank_i,
    input  logic [31:0]                           cfg_wdata_i,
    output logic [31:0]                           cfg_rdata_o,
    // Data memory
    output logic                                  mem_req_o,
    output logic                                  mem_we_o,
    output logic [MemAddrWidth-1:0]               mem_addr_o,
    output logic [fpss_pkg::FLEN-1:0]             mem_wdata_o,
    input  logic                                  mem_gnt_i,
    input  logic                                  mem_rvalid_i,
    input  logic [fpss_pkg::FLEN-1:0]             mem_rdata_i,
    // Responses
    output logic                                  rsp_valid_o,
    input  logic                                  rsp_ready_i,
    output logic [fpss_pkg::FLEN-1:0]             rsp_data_o,
    output logic [RspIdWidth-1:0]                 rsp_id_o
);

    logic [PhysAddrWidth-1:0]  rf_raddr1;
    logic [PhysAddrWidth-1:0]  rf_raddr2;
    logic [fpss_pkg::FLEN-1:0] rf_rdata1;
    logic [fpss_pkg::FLEN-1:0] rf_rdata2;
    logic                      rf_we;
    logic [PhysAddrWidth-1:0]  rf_waddr;
    logic [fpss_pkg::FLEN-1:0] rf_wdata;
    logic                      clr_valid;
    logic [PhysAddrWidth-1:0]  clr_addr;

    fpss_issue_if #(.PhysAddrWidth(PhysAddrWidth), .RspIdWidth(RspIdWidth)) issue_bus ();
    fpss_wb_if #(.PhysAddrWidth(PhysAddrWidth), .RspIdWidth(RspIdWidth)) sgnj_wb ();
    fpss_wb_if #(.PhysAddrWidth(PhysAddrWidth), .RspIdWidth(RspIdWidth)) lsu_wb ();

    fpss_issue #(
        .PhysAddrWidth (PhysAddrWidth),
        .RspIdWidth    (RspIdWidth)
    ) i_issue (
        .clk_i,
        .reset_i,
        .instr_valid_i,
        .instr_ready_o,
        .instr_op_i,
        .instr_rd_i,
        .instr_rs1_i,
        .instr_rs2_i,
        .instr_imm_i,
        .instr_id_i,
        .cfg_write_i,
        .cfg_bank_i,
        .cfg_wdata_i,
        .cfg_rdata_o,
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .clr_valid_i (clr_valid),
        .clr_addr_i  (clr_addr),
        .issue       (issue_bus)
    );

    fpss_regfile #(
        .PhysAddrWidth (PhysAddrWidth)
    ) i_regfile (
        .clk_i,
        .reset_i,
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

    fpss_sgnj_unit #(
        .PhysAddrWidth (PhysAddrWidth),
        .RspIdWidth    (RspIdWidth)
    ) i_sgnj_unit (
        .clk_i,
        .reset_i,
        .issue (issue_bus),
        .wb    (sgnj_wb)
    );

    fpss_lsu #(
        .PhysAddrWidth  (PhysAddrWidth),
        .MemAddrWidth   (MemAddrWidth),
        .MaxOutstanding (MaxOutstanding)
    ) i_lsu (
        .clk_i,
        .reset_i,
        .issue (issue_bus),
        .wb    (lsu_wb),
        .mem_req_o,
        .mem_we_o,
        .mem_addr_o,
        .mem_wdata_o,
        .mem_gnt_i,
        .mem_rvalid_i,
        .mem_rdata_i
    );

    fpss_writeback #(
        .PhysAddrWidth (PhysAddrWidth),
        .RspIdWidth    (RspIdWidth)
    ) i_writeback (
        .clk_i,
        .reset_i,
        .sgnj        (sgnj_wb),
        .lsu         (lsu_wb),
        .rf_we_o     (rf_we),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata),
        .clr_valid_o (clr_valid),
        .clr_addr_o  (clr_addr),
        .rsp_valid_o,
        .rsp_ready_i,
        .rsp_data_o,
        .rsp_id_o
    );

endmodule

/* tests/tb_fpss.sv */
module tb_fpss;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned Timeout = 1000;
    localparam logic [31:0] Seed    = 32'hf2cdcab5;

    logic                    clk_i;
    logic                    reset_i;
    logic                    instr_valid_i;
    logic                    instr_ready_o;
    fpss_pkg::opcode_e       instr_op_i;
    logic [4:0]              instr_rd_i;
    logic [4:0]              instr_rs1_i;
    logic [4:0]              instr_rs2_i;
    logic [31:0]             instr_imm_i;
    logic [3:0]              instr_id_i;
    logic                    cfg_write_i;
    logic [1:0]              cfg_bank_i;
    logic [31:0]             cfg_wdata_i;
    logic [31:0]             cfg_rdata_o;
    logic                    mem_req_o;
    logic                    mem_we_o;
    logic [15:0]             mem_addr_o;
    logic [31:0]             mem_wdata_o;
    logic                    mem_gnt_i;
    logic                    mem_rvalid_i;
    logic [31:0]             mem_rdata_i;
    logic                    rsp_valid_o;
    logic                    rsp_ready_i;
    logic [31:0]             rsp_data_o;
    logic [3:0]              rsp_id_o;

    int unsigned             errors;
    int unsigned             timeouts;
    logic [31:0]             rng_state;
    logic [31:0]             mem [65536];
    logic [31:0]             load_q [$];
    int unsigned             load_wait;
    logic [31:0]             exp_data_q [$];
    logic [3:0]              exp_id_q [$];
    logic [31:0]             want_data;
    logic [3:0]              want_id;

    fpss_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // --------------------
    // Memory and response models
    // --------------------
    always @(posedge clk_i) begin
        if (!reset_i && mem_req_o && mem_gnt_i) begin
            if (mem_we_o) begin
                mem[mem_addr_o] = mem_wdata_o;
            end else begin
                load_q.push_back(mem[mem_addr_o]);
            end
        end
        if (!reset_i && rsp_valid_o && rsp_ready_i) begin
            assert (exp_data_q.size() != 0) else begin
                errors++;
                $display("Response with id %0d and data %h arrived with none expected",
                         rsp_id_o, rsp_data_o);
            end
            if (exp_data_q.size() != 0) begin
                want_data = exp_data_q.pop_front();
                want_id   = exp_id_q.pop_front();
                assert (rsp_data_o == want_data) else begin
                    errors++;
                    $display("Error: %t rsp_data_o got %h expected %h",
                             $realtime, rsp_data_o, want_data);
                end
                assert (rsp_id_o == want_id) else begin
                    errors++;
                    $display("Error: %t rsp_id_o got %h expected %h",
                             $realtime, rsp_id_o, want_id);
                end
            end
        end
        #1;
        rng_state    = xorshift32(rng_state);
        mem_gnt_i    = rng_state[1:0] != 2'b00;
        rsp_ready_i  = rng_state[3:2] != 2'b00;
        mem_rvalid_i = 1'b0;
        // In-order read data with a random gap
        if (load_q.size() != 0) begin
            if (load_wait == 0) begin
                mem_rvalid_i = 1'b1;
                mem_rdata_i  = load_q.pop_front();
                load_wait    = rng_state[6:4] % 4;
            end else begin
                load_wait--;
            end
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic wait_idle();
        int unsigned cycles;
        int unsigned quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < 3 && cycles < Timeout) begin
            @(posedge clk_i);
            cycles++;
            if (exp_data_q.size() == 0 && load_q.size() == 0 && !mem_rvalid_i
                && !rsp_valid_o) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        #1;
        if (quiet < 3) begin
            timeouts++;
            $display("Timeout while waiting for outstanding work to drain");
        end
    endtask

    task automatic write_offset(input int bank, input int value);
        wait_idle();
        cfg_write_i = 1'b1;
        cfg_bank_i  = bank[1:0];
        cfg_wdata_i = value;
        @(posedge clk_i);
        #1;
        cfg_write_i = 1'b0;
    endtask

    task automatic check_offset(input int bank, input int expected);
        wait_idle();
        cfg_bank_i = bank[1:0];
        @(posedge clk_i);
        assert (cfg_rdata_o == 32'(expected)) else begin
            errors++;
            $display("Error: %t cfg_rdata_o got %h expected %h",
                     $realtime, cfg_rdata_o, 32'(expected));
        end
        #1;
    endtask

    task automatic send_instr(input int op, input int rd, input int rs1, input int rs2,
                              input logic [31:0] imm, input int id, input int has_rsp,
                              input logic [31:0] expected);
        int unsigned waited;
        instr_valid_i = 1'b1;
        instr_op_i    = fpss_pkg::opcode_e'(op);
        instr_rd_i    = rd[4:0];
        instr_rs1_i   = rs1[4:0];
        instr_rs2_i   = rs2[4:0];
        instr_imm_i   = imm;
        instr_id_i    = id[3:0];
        waited        = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!instr_ready_o && waited < Timeout);
        if (instr_ready_o) begin
            if (has_rsp != 0) begin
                exp_data_q.push_back(expected);
                exp_id_q.push_back(id[3:0]);
            end
        end else begin
            timeouts++;
            $display("Timeout: instruction with id %0d was never accepted", id);
        end
        #1;
        instr_valid_i = 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int                fd;
        int                n;
        bit                at_end;
        logic [7:0]        kind;
        logic [8*200-1:0]  skip_buf;
        int                op;
        int                rd;
        int                rs1;
        int                rs2;
        int                id;
        int                has_rsp;
        logic [31:0]       imm;
        logic [31:0]       expected;

        $timeformat(-9, 0, " ns", 0);
        errors        = 0;
        timeouts      = 0;
        rng_state     = Seed;
        load_wait     = 0;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_op_i    = fpss_pkg::OP_MV_W_X;
        instr_rd_i    = '0;
        instr_rs1_i   = '0;
        instr_rs2_i   = '0;
        instr_imm_i   = '0;
        instr_id_i    = '0;
        cfg_write_i   = 1'b0;
        cfg_bank_i    = '0;
        cfg_wdata_i   = '0;
        mem_gnt_i     = 1'b0;
        mem_rvalid_i  = 1'b0;
        mem_rdata_i   = '0;
        rsp_ready_i   = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = {~a[15:0], a[15:0]};
        end

        repeat (4) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        @(posedge clk_i);
        assert (mem_req_o === 1'b0) else begin
            errors++;
            $display("Error: %t mem_req_o got %b expected 0", $realtime, mem_req_o);
        end
        assert (rsp_valid_o === 1'b0) else begin
            errors++;
            $display("Error: %t rsp_valid_o got %b expected 0", $realtime, rsp_valid_o);
        end
        #1;

        fd     = $fopen("tests/fpss_vectors.txt", "r");
        at_end = (fd == 0);
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file");
        end
        while (!at_end && timeouts == 0) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (kind == "#") begin
                n = $fgets(skip_buf, fd);
            end else if (kind == "W" || kind == "R") begin
                n = $fscanf(fd, "%d %d", rd, id);
                if (n != 2) begin
                    errors++;
                    $display("Malformed config line in the vector file");
                    at_end = 1'b1;
                end else if (kind == "W") begin
                    write_offset(rd, id);
                end else begin
                    check_offset(rd, id);
                end
            end else if (kind == "I") begin
                n = $fscanf(fd, "%d %d %d %d %h %d %d %h",
                            op, rd, rs1, rs2, imm, id, has_rsp, expected);
                if (n != 8) begin
                    errors++;
                    $display("Malformed instruction line in the vector file");
                    at_end = 1'b1;
                end else begin
                    send_instr(op, rd, rs1, rs2, imm, id, has_rsp, expected);
                end
            end else begin
                errors++;
                $display("Unknown record type in the vector file");
                at_end = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        if (timeouts == 0) begin
            wait_idle();
        end
        assert (exp_data_q.size() == 0) else begin
            errors++;
            $display("%0d expected responses never arrived", exp_data_q.size());
        end

        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tests/fpss_vectors.txt */
# W bank offset | R bank expected_offset (decimal)
# I op rd rs1 rs2 imm(hex) id rsp expected(hex); op 0 mvwx 1 mvxw 2 sgnj 3 sgnjn 4 sgnjx 5 min 6 max 7 flw 8 fsw
R 0 0
R 1 1
R 2 2
R 3 3
I 0 1 0 0 3f800000 1 0 0
I 1 0 1 0 0 2 1 3f800000
I 0 2 0 0 40490fdb 3 0 0
I 0 3 0 0 c0000000 4 0 0
I 2 4 2 3 0 5 0 0
I 1 0 4 0 0 6 1 c0490fdb
I 3 5 2 3 0 7 0 0
I 1 0 5 0 0 8 1 40490fdb
I 4 6 3 3 0 9 0 0
I 1 0 6 0 0 10 1 40000000
I 5 7 2 3 0 11 0 0
I 1 0 7 0 0 12 1 c0000000
I 6 8 2 3 0 13 0 0
I 1 0 8 0 0 14 1 40490fdb
I 0 10 0 0 80000000 15 0 0
I 5 13 10 12 0 0 0 0
I 1 0 13 0 0 1 1 80000000
I 6 14 10 12 0 2 0 0
I 1 0 14 0 0 3 1 00000000
I 0 15 0 0 c0400000 4 0 0
I 5 9 3 15 0 5 0 0
I 1 0 9 0 0 6 1 c0400000
I 6 9 3 15 0 7 0 0
I 1 0 9 0 0 8 1 c0000000
# Store, load back, and an op that depends on a load
I 8 0 0 2 100 9 0 0
I 7 16 0 0 100 10 0 0
I 1 0 16 0 0 11 1 40490fdb
I 7 17 0 0 1234 12 0 0
I 3 18 17 17 0 13 0 0
I 1 0 18 0 0 14 1 6dcb1234
# Several loads in flight
I 8 0 0 3 200 15 0 0
I 8 0 0 15 201 0 0 0
I 8 0 0 10 202 1 0 0
I 7 20 0 0 200 2 0 0
I 7 21 0 0 201 3 0 0
I 7 22 0 0 202 4 0 0
I 7 23 0 0 203 5 0 0
I 1 0 20 0 0 6 1 c0000000
I 1 0 21 0 0 7 1 c0400000
I 1 0 22 0 0 8 1 80000000
I 1 0 23 0 0 9 1 fdfc0203
# Bank 1 on top of bank 0, names 3 and 11 alias
W 1 0
R 1 0
I 0 11 0 0 12345678 10 0 0
I 1 0 3 0 0 11 1 12345678
I 0 3 0 0 cafef00d 12 0 0
I 1 0 11 0 0 13 1 cafef00d
W 1 1
R 1 1

/* tb.f */
src/fpss_pkg.sv
src/fpss_wb_if.sv
src/fpss_issue_if.sv
src/fpss_issue.sv
src/fpss_regfile.sv
src/fpss_sgnj_unit.sv
src/fpss_lsu.sv
src/fpss_writeback.sv
src/fpss_top.sv
tests/tb_fpss.sv

/* Bender.yml */
package:
  name: fpss

sources:
  - files:
      - src/fpss_pkg.sv
      - src/fpss_wb_if.sv
      - src/fpss_issue_if.sv
      - src/fpss_issue.sv
      - src/fpss_regfile.sv
      - src/fpss_sgnj_unit.sv
      - src/fpss_lsu.sv
      - src/fpss_writeback.sv
      - src/fpss_top.sv
  - target: test
    files:
      - tests/tb_fpss.sv
